//--- verilog/loader_pkg.sv
package loader_pkg;

    // three address bytes carry 7 + 8 + 7 bits of word address
    localparam int ADDR_W = 22;
    localparam int DATA_W = 16;

    localparam logic [7:0] CMD_WRITE = 8'd1;  // data bytes follow the address
    localparam logic [7:0] CMD_END   = 8'd2;  // host is done loading the image

    // decoder phases within one chip select window
    typedef enum logic [1:0] {
        ST_CMD,
        ST_ADDR,
        ST_DATA
    } cmd_state_t;

endpackage

//--- verilog/spi_bus.sv
`timescale 1ns/10ps

// byte stream from the SPI receiver toward the command decoder
interface spi_bus ();

    logic [7:0] read;        // valid only while read_valid is high
    logic       read_valid;  // one pulse per received byte
    logic       transm_end;  // one pulse when chip select is released

    modport master (
        input read,
        input read_valid,
        input transm_end
    );

    modport slave (
        output read,
        output read_valid,
        output transm_end
    );

endinterface

//--- verilog/sdram_bus.sv
`timescale 1ns/10ps

interface sdram_bus import loader_pkg::*; ();

    logic              req;         // single cycle, carries we, address and data
    logic              we;
    logic [ADDR_W-1:0] address;
    logic [DATA_W-1:0] data_write;
    logic              busy;        // high for the length of an access

    modport master (
        output req,
        output we,
        output address,
        output data_write,
        input  busy
    );

    modport slave (
        input  req,
        input  we,
        input  address,
        input  data_write,
        output busy
    );

endinterface

//--- verilog/spi_byte_rx.sv
`timescale 1ns/10ps

// SPI mode 0 byte receiver, sclk must stay at or below clk/4
module spi_byte_rx (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  sclk,
    input  logic  mosi,
    input  logic  cs_n,
    spi_bus.slave spi
);
    logic [2:0] sclk_sync;  // two synchronizer stages plus one for edge detection
    logic [2:0] cs_sync;
    logic [1:0] mosi_sync;
    logic [2:0] bit_cnt;
    logic [7:0] shift;
    logic       sclk_rise;
    logic       cs_rise;
    logic       cs_fall;
    logic       cs_active;

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign cs_rise   = cs_sync[1] & ~cs_sync[2];
    assign cs_fall   = ~cs_sync[1] & cs_sync[2];
    assign cs_active = ~cs_sync[1];

    // the shift register already holds the full byte when read_valid fires
    assign spi.read = shift;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sclk_sync      <= '0;
            cs_sync        <= '1;  // chip select idles high
            bit_cnt        <= '0;
            spi.read_valid <= 1'b0;
            spi.transm_end <= 1'b0;
        end else begin
            sclk_sync      <= {sclk_sync[1:0], sclk};
            cs_sync        <= {cs_sync[1:0], cs_n};
            spi.read_valid <= 1'b0;
            spi.transm_end <= cs_rise;

            if (cs_fall) begin
                bit_cnt <= '0;  // a new transfer always starts on a byte boundary
            end else if (sclk_rise && cs_active) begin
                bit_cnt        <= bit_cnt + 3'd1;
                spi.read_valid <= (bit_cnt == 3'd7);
            end
        end
    end

    always_ff @(posedge clk) begin
        mosi_sync <= {mosi_sync[0], mosi};  // same delay as the sclk path
        if (sclk_rise && cs_active) begin
            shift <= {shift[6:0], mosi_sync[1]};  // MSB first
        end
    end

    // sclk rising edges must be at least four clk cycles apart
    assert property (@(posedge clk) disable iff (!rst_n)
        sclk_rise |-> !$past(sclk_rise, 1) && !$past(sclk_rise, 2)
                      && !$past(sclk_rise, 3))
    else $error("spi_byte_rx: sclk runs faster than clk/4");

endmodule

//--- verilog/load_cmd_decoder.sv
`timescale 1ns/10ps

module load_cmd_decoder
    import loader_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    output logic     loading,
    spi_bus.master   spi,
    sdram_bus.master sdram
);
    cmd_state_t        state;
    logic [1:0]        addr_cnt;
    logic [7:0]        cmd;
    logic              high_byte;   // next data byte is the upper half of a word
    logic              first_word;  // no write issued yet in this transfer
    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        data_lo;
    logic [7:0]        data_hi;
    logic              take_byte;
    logic              write_hi;

    assign take_byte = spi.read_valid && !spi.transm_end;
    assign write_hi  = take_byte && state == ST_DATA && cmd == CMD_WRITE && high_byte;

    assign sdram.address    = addr_q;
    assign sdram.data_write = {data_hi, data_lo};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_CMD;
            addr_cnt   <= '0;
            high_byte  <= 1'b0;
            first_word <= 1'b0;
            loading    <= 1'b0;
            data_lo    <= '0;
            sdram.req  <= 1'b0;
            sdram.we   <= 1'b0;
        end else begin
            sdram.req <= 1'b0;
            if (spi.transm_end) begin
                state <= ST_CMD;  // a released chip select drops any partial parse
            end else if (spi.read_valid) begin
                case (state)
                    ST_CMD: begin
                        addr_cnt <= '0;
                        if (spi.read == CMD_END) begin
                            loading <= 1'b0;
                        end else begin
                            state <= ST_ADDR;
                        end
                    end
                    ST_ADDR: begin
                        addr_cnt <= addr_cnt + 2'd1;
                        if (addr_cnt == 2'd2) begin
                            high_byte  <= spi.read[0];  // lsb of the last address byte
                            first_word <= 1'b1;
                            state      <= ST_DATA;
                        end
                    end
                    ST_DATA: begin
                        if (cmd == CMD_WRITE) begin
                            loading   <= 1'b1;
                            high_byte <= !high_byte;
                            if (high_byte) begin
                                sdram.req  <= 1'b1;
                                sdram.we   <= 1'b1;
                                first_word <= 1'b0;
                            end else begin
                                data_lo <= spi.read;  // kept across transfers
                            end
                        end
                    end
                    default: state <= ST_CMD;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_byte && state == ST_CMD) begin
            cmd <= spi.read;
        end
        if (take_byte && state == ST_ADDR) begin
            case (addr_cnt)
                2'd0:    addr_q[21:15] <= spi.read[6:0];
                2'd1:    addr_q[14:7]  <= spi.read;
                2'd2:    addr_q[6:0]   <= spi.read[7:1];
                default: ;
            endcase
        end
        if (write_hi) begin
            data_hi <= spi.read;
            if (!first_word) begin
                addr_q <= addr_q + 1'b1;  // the first word goes to the given address
            end
        end
    end

    // a write carries a fully parsed address and both data bytes
    assert property (@(posedge clk) disable iff (!rst_n)
        sdram.req |-> !$isunknown({sdram.address, sdram.data_write}))
    else $error("load_cmd_decoder: write request with unknown address or data");

endmodule

//--- verilog/sdram_ctrl.sv
`timescale 1ns/10ps

// word memory behind a fixed busy period, writes win over the system read
module sdram_ctrl
    import loader_pkg::*;
#(
    parameter int MEM_AW        = 10,
    parameter int ACCESS_CYCLES = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    sdram_bus.slave           sdram,
    input  logic              rd_req,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data,
    output logic              rd_valid
);
    localparam int CNT_W = (ACCESS_CYCLES > 1) ? $clog2(ACCESS_CYCLES) : 1;

    logic [DATA_W-1:0] mem [2**MEM_AW];

    logic              busy;
    logic [CNT_W-1:0]  cnt;
    logic              act_we;
    logic [MEM_AW-1:0] act_addr;
    logic [DATA_W-1:0] act_data;
    logic              pend_valid;
    logic [MEM_AW-1:0] pend_addr;
    logic [DATA_W-1:0] pend_data;
    logic              rd_wait;
    logic [MEM_AW-1:0] rd_wait_addr;

    logic wr_req;
    logic start_pend;
    logic start_req;
    logic start_write;
    logic start_wait_rd;
    logic start_new_rd;
    logic access_done;

    // this bus only carries writes, requests without we are ignored
    assign wr_req        = sdram.req && sdram.we;
    assign start_pend    = !busy && pend_valid;
    assign start_req     = !busy && !pend_valid && wr_req;
    assign start_write   = start_pend || start_req;
    assign start_wait_rd = !busy && !start_write && rd_wait;
    assign start_new_rd  = !busy && !start_write && !rd_wait && rd_req;
    assign access_done   = busy && cnt == '0;

    assign sdram.busy = busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            cnt        <= '0;
            act_we     <= 1'b0;
            pend_valid <= 1'b0;
            rd_wait    <= 1'b0;
            rd_valid   <= 1'b0;
        end else begin
            rd_valid <= 1'b0;
            if (start_write || start_wait_rd || start_new_rd) begin
                busy   <= 1'b1;
                cnt    <= CNT_W'(ACCESS_CYCLES - 1);
                act_we <= start_write;
            end else if (access_done) begin
                busy     <= 1'b0;  // one idle cycle follows every access
                rd_valid <= !act_we;
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end

            if (start_pend) begin
                pend_valid <= wr_req;  // a request in the drain cycle refills the slot
            end else if (wr_req && busy) begin
                pend_valid <= 1'b1;
            end

            if (start_wait_rd) begin
                rd_wait <= 1'b0;
            end else if (rd_req && !start_new_rd) begin
                rd_wait <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_pend) begin
            act_addr <= pend_addr;
            act_data <= pend_data;
        end else if (start_req) begin
            act_addr <= sdram.address[MEM_AW-1:0];  // upper bits wrap
            act_data <= sdram.data_write;
        end else if (start_wait_rd) begin
            act_addr <= rd_wait_addr;
        end else if (start_new_rd) begin
            act_addr <= rd_addr[MEM_AW-1:0];
        end

        if (wr_req && !start_req) begin
            pend_addr <= sdram.address[MEM_AW-1:0];
            pend_data <= sdram.data_write;
        end
        if (rd_req && !start_new_rd) begin
            rd_wait_addr <= rd_addr[MEM_AW-1:0];
        end

        if (access_done) begin
            if (act_we) begin
                mem[act_addr] <= act_data;
            end else begin
                rd_data <= mem[act_addr];
            end
        end
    end

    // the decoder must leave room between words for the slot to drain
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_req && busy |-> !pend_valid)
    else $error("sdram_ctrl: write request lost, pending slot full");

    assert property (@(posedge clk) disable iff (!rst_n)
        rd_req |-> !rd_wait && !(busy && !act_we))
    else $error("sdram_ctrl: read requested while another read is outstanding");

endmodule

//--- verilog/rom_loader_top.sv
`timescale 1ns/10ps

module rom_loader_top
    import loader_pkg::*;
#(
    parameter int MEM_AW        = 10,
    parameter int ACCESS_CYCLES = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              spi_sclk,
    input  logic              spi_mosi,
    input  logic              spi_cs_n,
    input  logic              rd_req,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic              loading,
    output logic [DATA_W-1:0] rd_data,
    output logic              rd_valid
);
    spi_bus   u_spi_bus ();
    sdram_bus u_sdram_bus ();

    spi_byte_rx u_spi_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .sclk  (spi_sclk),
        .mosi  (spi_mosi),
        .cs_n  (spi_cs_n),
        .spi   (u_spi_bus.slave)
    );

    load_cmd_decoder u_decoder (
        .clk     (clk),
        .rst_n   (rst_n),
        .loading (loading),
        .spi     (u_spi_bus.master),
        .sdram   (u_sdram_bus.master)
    );

    sdram_ctrl #(
        .MEM_AW        (MEM_AW),
        .ACCESS_CYCLES (ACCESS_CYCLES)
    ) u_sdram_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .sdram    (u_sdram_bus.slave),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

endmodule

//--- sim/tb_rom_loader.sv
`timescale 1ns/10ps

module tb_rom_loader
    import loader_pkg::*;
();
    localparam int MEM_AW        = 10;
    localparam int ACCESS_CYCLES = 4;
    localparam int SCLK_HALF     = 4;  // clk cycles per sclk half period, so sclk is clk/8
    localparam int SETTLE        = 3 + 1 + 2 * (ACCESS_CYCLES + 1) + 4;
    localparam int RD_TIMEOUT    = 100;
    localparam int N_TESTS       = 8;

    typedef struct packed {
        logic [7:0]        cmd;
        logic [ADDR_W-1:0] addr;
        logic              start_high;
        logic [1:0]        addr_bytes;  // below 3 the chip select is released early
        logic [4:0]        n_bytes;
        logic              exp_loading;
    } stim_t;

    logic              clk;
    logic              rst_n;
    logic              spi_sclk;
    logic              spi_mosi;
    logic              spi_cs_n;
    logic              rd_req;
    logic [ADDR_W-1:0] rd_addr;
    logic              loading;
    logic [DATA_W-1:0] rd_data;
    logic              rd_valid;

    stim_t             stim [N_TESTS];
    logic [15:0]       lfsr;
    logic [7:0]        data_buf [32];
    logic [DATA_W-1:0] sb_mem [2**MEM_AW];
    logic              sb_written [2**MEM_AW];
    logic [7:0]        sb_last_lo;  // mirrors the low data register of the decoder
    int                errors;
    int                checks;
    int                test_errors;
    int                test_checks;

    rom_loader_top #(
        .MEM_AW        (MEM_AW),
        .ACCESS_CYCLES (ACCESS_CYCLES)
    ) u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_cs_n (spi_cs_n),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .loading  (loading),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    always #2 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[0] ^ s[2] ^ s[3] ^ s[5];
        return {fb, s[15:1]};
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b    = {b[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // every task leaves the time 1 ns after a rising edge
    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic spi_send_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            spi_mosi = b[i];  // mode 0, data settles while sclk is low
            tick(SCLK_HALF);
            spi_sclk = 1'b1;
            tick(SCLK_HALF);
            spi_sclk = 1'b0;
        end
    endtask

    task automatic run_transfer(input stim_t s);
        logic [7:0] ab [3];
        ab[0] = {1'b0, s.addr[21:15]};
        ab[1] = s.addr[14:7];
        ab[2] = {s.addr[6:0], s.start_high};
        spi_cs_n = 1'b0;
        tick(SCLK_HALF);
        spi_send_byte(s.cmd);
        for (int i = 0; i < s.addr_bytes; i++) begin
            spi_send_byte(ab[i]);
        end
        if (s.addr_bytes == 2'd3) begin
            for (int i = 0; i < s.n_bytes; i++) begin
                spi_send_byte(data_buf[i]);
            end
        end
        tick(SCLK_HALF);
        spi_cs_n = 1'b1;
        tick(SETTLE);  // long enough for the last word to land in memory
    endtask

    // low byte waits in a register, the high byte completes the word
    task automatic model_transfer(input stim_t s);
        logic              hi;
        logic              first;
        logic [ADDR_W-1:0] waddr;
        hi    = s.start_high;
        first = 1'b1;
        waddr = s.addr;
        if (s.cmd == CMD_WRITE && s.addr_bytes == 2'd3) begin
            for (int i = 0; i < s.n_bytes; i++) begin
                if (hi) begin
                    if (!first) begin
                        waddr = waddr + 1'b1;
                    end
                    sb_mem[waddr[MEM_AW-1:0]]     = {data_buf[i], sb_last_lo};
                    sb_written[waddr[MEM_AW-1:0]] = 1'b1;
                    first = 1'b0;
                end else begin
                    sb_last_lo = data_buf[i];
                end
                hi = !hi;
            end
        end
    endtask

    task automatic check_word(input int idx);
        logic [DATA_W-1:0] got;
        logic              ok;
        ok      = 1'b0;
        rd_addr = ADDR_W'(idx);
        rd_req  = 1'b1;
        tick(1);
        rd_req  = 1'b0;
        for (int t = 0; t < RD_TIMEOUT && !ok; t++) begin
            if (rd_valid) begin
                got = rd_data;
                ok  = 1'b1;
            end else begin
                tick(1);
            end
        end
        test_checks++;
        if (!ok) begin
            $display("read of address %h timed out, rd_valid never came", idx);
            test_errors++;
        end else if (got !== sb_mem[idx]) begin
            $display("** Error at %0t: address %h expected %h got %h",
                     $time, idx, sb_mem[idx], got);
            test_errors++;
        end
    endtask

    task automatic check_memory();
        for (int a = 0; a < 2**MEM_AW; a++) begin
            if (sb_written[a]) begin
                check_word(a);
            end
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        spi_sclk = 1'b0;
        spi_mosi = 1'b0;
        spi_cs_n = 1'b1;
        rd_req   = 1'b0;
        rd_addr  = '0;
        lfsr     = 16'd4;
        errors   = 0;
        checks   = 0;
        sb_last_lo = 8'h00;
        for (int a = 0; a < 2**MEM_AW; a++) begin
            sb_written[a] = 1'b0;
        end

        stim[0] = '{CMD_WRITE, 22'h000010, 1'b0, 2'd3, 5'd8, 1'b1};
        stim[1] = '{CMD_WRITE, 22'h3f0020, 1'b0, 2'd3, 5'd5, 1'b1};  // upper bits wrap
        stim[2] = '{CMD_WRITE, 22'h000040, 1'b1, 2'd3, 5'd5, 1'b1};
        stim[3] = '{8'd5,      22'h000010, 1'b0, 2'd3, 5'd6, 1'b1};
        stim[4] = '{CMD_END,   22'h000000, 1'b0, 2'd0, 5'd0, 1'b0};
        stim[5] = '{CMD_WRITE, 22'h000100, 1'b0, 2'd2, 5'd0, 1'b0};
        stim[6] = '{CMD_WRITE, 22'h000011, 1'b0, 2'd3, 5'd4, 1'b1};
        stim[7] = '{CMD_END,   22'h000000, 1'b0, 2'd0, 5'd0, 1'b0};

        tick(16);
        rst_n = 1'b1;
        tick(2);

        // quiet state right after reset
        test_errors = 0;
        test_checks = 1;
        if (loading !== 1'b0) begin
            $display("** Error at %0t: loading expected 0 got %b after reset", $time, loading);
            test_errors++;
        end
        for (int i = 0; i < 20; i++) begin
            if (rd_valid !== 1'b0) begin
                $display("** Error at %0t: rd_valid high with no read requested", $time);
                test_errors++;
            end
            tick(1);
        end
        $display("test 0 reset: %0d checks, %0d errors", test_checks, test_errors);
        errors += test_errors;
        checks += test_checks;

        for (int t = 0; t < N_TESTS; t++) begin
            test_errors = 0;
            test_checks = 1;
            if (stim[t].addr_bytes == 2'd3) begin
                for (int i = 0; i < stim[t].n_bytes; i++) begin
                    rand_byte(data_buf[i]);
                end
            end
            run_transfer(stim[t]);
            model_transfer(stim[t]);
            if (loading !== stim[t].exp_loading) begin
                $display("** Error at %0t: loading expected %b got %b",
                         $time, stim[t].exp_loading, loading);
                test_errors++;
            end
            check_memory();
            $display("test %0d cmd %h addr %h: %0d checks, %0d errors",
                     t + 1, stim[t].cmd, stim[t].addr, test_checks, test_errors);
            errors += test_errors;
            checks += test_checks;
        end

        $display("tests %0d, checks %0d, errors %0d", N_TESTS + 1, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- loader.f
verilog/loader_pkg.sv
verilog/spi_bus.sv
verilog/sdram_bus.sv
verilog/spi_byte_rx.sv
verilog/load_cmd_decoder.sv
verilog/sdram_ctrl.sv
verilog/rom_loader_top.sv
sim/tb_rom_loader.sv

//--- Makefile
# Verilator simulation of the ROM loader

VERILATOR ?= verilator
TOP       ?= tb_rom_loader
FILELIST  ?= loader.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# the run passes only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
